//--- files.f
src/spart_pkg.sv
src/host_pkg.sv
src/spart_baud_gen.sv
src/spart_tx.sv
src/spart_rx.sv
src/spart.sv
src/spart_driver.sv
src/spart_system.sv
sim/tb_spart_system.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -Wno-fatal
TOP       := tb_spart_system
FILELIST  := files.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- sim/tb_spart_system.sv
`timescale 1ns/1ps

module tb_spart_system
	import spart_pkg::*, host_pkg::*;
();

	localparam int HALF_PERIOD = 20;
	localparam int PERIOD = 2 * HALF_PERIOD;
	localparam logic [31:0] SEED = 32'hc5b;
	// Cycles per serial bit from the programmed divisor
	localparam int BIT_CYCLES = OVERSAMPLE * (int'({DIV_HI, DIV_LO}) + 1);
	localparam int HALF_BIT = BIT_CYCLES / 2;
	// Ten bits per frame, four frames per word, ten words in all
	localparam int TEST_BITS = 400;
	localparam int WATCHDOG_CYCLES = (TEST_BITS + 40) * BIT_CYCLES;

	logic        clk;
	logic        rst;
	logic        wren;
	logic        rden;
	word_t       data_tx;
	logic        clear_status_rd;
	word_t       data_rx;
	status_t     status_register;
	logic        data_rdy;
	logic        txd;
	logic        rxd;
	logic [31:0] lfsr;

	spart_system spart_system_inst (
		.clk             (clk),
		.rst             (rst),
		.wren            (wren),
		.rden            (rden),
		.data_tx         (data_tx),
		.clear_status_rd (clear_status_rd),
		.data_rx         (data_rx),
		.status_register (status_register),
		.data_rdy        (data_rdy),
		.txd             (txd),
		.rxd             (rxd)
	);

	always #HALF_PERIOD clk = ~clk;

	//////////////////////////////////////////////////
	// Failure reporting and checks
	//////////////////////////////////////////////////

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
			fail_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, expected));
	endtask

	// Whole run bounded by the serial traffic of all tests
	initial
	begin
		#(WATCHDOG_CYCLES * PERIOD);
		fail_run($sformatf("timeout, tests still running after %0d cycles", WATCHDOG_CYCLES));
	end

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	// Poll one status bit on falling edges
	task automatic wait_status(input int idx, input logic value, input int limit,
		input string what);
		int n;
		n = 0;
		while (status_register[idx] !== value && n < limit)
		begin
			@(negedge clk);
			n++;
		end
		if (status_register[idx] !== value)
			fail_run($sformatf("timed out waiting for %s", what));
	endtask

	//////////////////////////////////////////////////
	// Random words
	//////////////////////////////////////////////////

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit
	task automatic random_word(output word_t w);
		for (int i = 0; i < 32; i++)
		begin
			lfsr = lfsr_next(lfsr);
			w[i] = lfsr[0];
		end
	endtask

	//////////////////////////////////////////////////
	// Serial line model
	//////////////////////////////////////////////////

	// 8N1 frame on rxd, LSB first
	task automatic send_byte(input logic [7:0] b);
		@(negedge clk);
		rxd = 1'b0;
		wait_cycles(BIT_CYCLES);
		for (int i = 0; i < 8; i++)
		begin
			rxd = b[i];
			wait_cycles(BIT_CYCLES);
		end
		rxd = 1'b1;
		wait_cycles(BIT_CYCLES);
	endtask

	task automatic send_word(input word_t w);
		for (int k = 0; k < 4; k++)
			send_byte(w[8 * k +: 8]);
	endtask

	// Sample txd at mid-bit from the falling start edge
	task automatic expect_txd_byte(input logic [7:0] expected, input string name);
		logic [7:0] b;
		@(negedge txd);
		wait_cycles(HALF_BIT);
		if (txd !== 1'b0)
			fail_run("start bit on txd went high before mid-bit");
		for (int i = 0; i < 8; i++)
		begin
			wait_cycles(BIT_CYCLES);
			b[i] = txd;
		end
		wait_cycles(BIT_CYCLES);
		if (txd !== 1'b1)
			fail_run("stop bit on txd was low");
		check_value(name, 32'(b), 32'(expected));
	endtask

	task automatic expect_txd_word(input word_t w);
		for (int k = 0; k < 4; k++)
			expect_txd_byte(w[8 * k +: 8], $sformatf("txd byte %0d", k));
	endtask

	//////////////////////////////////////////////////
	// Host side strobes
	//////////////////////////////////////////////////

	task automatic write_word(input word_t w);
		@(negedge clk);
		data_tx = w;
		wren = 1'b1;
		@(negedge clk);
		wren = 1'b0;
	endtask

	task automatic pulse_rden();
		@(negedge clk);
		rden = 1'b1;
		@(negedge clk);
		rden = 1'b0;
	endtask

	task automatic clear_read_done();
		@(negedge clk);
		clear_status_rd = 1'b1;
		@(negedge clk);
		clear_status_rd = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////

	task automatic reset_state();
		check_value("status_register", status_register, 32'd1);
		check_value("data_rdy", 32'(data_rdy), 32'd0);
		check_value("txd", 32'(txd), 32'd1);
	endtask

	task automatic data_rdy_pulse();
		@(negedge clk);
		rden = 1'b1;
		check_value("data_rdy", 32'(data_rdy), 32'd0);
		@(negedge clk);
		rden = 1'b0;
		check_value("data_rdy", 32'(data_rdy), 32'd1);
		@(negedge clk);
		check_value("data_rdy", 32'(data_rdy), 32'd0);
		// Same for wren, which also starts a word
		data_tx = 32'h0ff0_5aa5;
		wren = 1'b1;
		check_value("data_rdy", 32'(data_rdy), 32'd0);
		@(negedge clk);
		wren = 1'b0;
		check_value("data_rdy", 32'(data_rdy), 32'd1);
		@(negedge clk);
		check_value("data_rdy", 32'(data_rdy), 32'd0);
		expect_txd_word(32'h0ff0_5aa5);
	endtask

	task automatic word_transmit();
		word_t w;
		w = 32'h8421_3c5a;
		wait_status(STAT_WRITE_READY, 1'b1, 2 * BIT_CYCLES, "write ready");
		write_word(w);
		check_value("write ready", 32'(status_register[STAT_WRITE_READY]), 32'd0);
		expect_txd_byte(w[7:0], "txd byte 0");
		// Word in progress, this one is dropped
		write_word(~w);
		check_value("write ready", 32'(status_register[STAT_WRITE_READY]), 32'd0);
		expect_txd_byte(w[15:8], "txd byte 1");
		expect_txd_byte(w[23:16], "txd byte 2");
		expect_txd_byte(w[31:24], "txd byte 3");
		check_value("status_register", status_register, 32'd1);
	endtask

	task automatic word_receive();
		word_t w;
		w = 32'hc3a5_1e78;
		check_value("read done", 32'(status_register[STAT_READ_DONE]), 32'd0);
		pulse_rden();
		send_word(w);
		wait_status(STAT_READ_DONE, 1'b1, BIT_CYCLES, "read done");
		check_value("data_rx", data_rx, w);
	endtask

	task automatic status_clear();
		word_t w;
		w = 32'h5e0f_a17c;
		clear_read_done();
		// Only write ready left
		check_value("status_register", status_register, 32'd1);
		send_word(w);
		wait_status(STAT_READ_DONE, 1'b1, BIT_CYCLES, "read done");
		check_value("data_rx", data_rx, w);
		check_value("status_register", status_register, 32'd3);
	endtask

	task automatic random_words();
		word_t w;
		for (int n = 0; n < 3; n++)
		begin
			random_word(w);
			wait_status(STAT_WRITE_READY, 1'b1, 2 * BIT_CYCLES, "write ready");
			write_word(w);
			expect_txd_word(w);
		end
		for (int n = 0; n < 3; n++)
		begin
			random_word(w);
			clear_read_done();
			send_word(w);
			wait_status(STAT_READ_DONE, 1'b1, BIT_CYCLES, "read done");
			check_value("data_rx", data_rx, w);
		end
	endtask

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		wren = 1'b0;
		rden = 1'b0;
		data_tx = '0;
		clear_status_rd = 1'b0;
		rxd = 1'b1;
		lfsr = SEED;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		reset_state();
		data_rdy_pulse();
		word_transmit();
		word_receive();
		status_clear();
		random_words();

		$display("Finished with no errors");
		$finish;
	end

endmodule

//--- src/spart_system.sv
`timescale 1ns/1ps

module spart_system
	import spart_pkg::*, host_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    wren,
	input  logic    rden,
	input  word_t   data_tx,
	input  logic    clear_status_rd,
	output word_t   data_rx,
	output status_t status_register,
	output logic    data_rdy,
	output logic    txd,
	input  logic    rxd
);

	// Byte bus between driver and SPART
	spart_cmd_t cmd;
	wire  [7:0] databus;
	logic       tbr;
	logic       rda;

	spart_driver spart_driver_inst (
		.clk             (clk),
		.rst             (rst),
		.cmd             (cmd),
		.databus         (databus),
		.rda             (rda),
		.tbr             (tbr),
		.clear_status_rd (clear_status_rd),
		.spart_data_wren (wren),
		.spart_data_rden (rden),
		.data_tx         (data_tx),
		.data_rx         (data_rx),
		.status_register (status_register),
		.data_rdy        (data_rdy)
	);

	spart spart_inst (
		.clk     (clk),
		.rst     (rst),
		.cmd     (cmd),
		.databus (databus),
		.tbr     (tbr),
		.rda     (rda),
		.txd     (txd),
		.rxd     (rxd)
	);

endmodule

//--- src/spart_driver.sv
`timescale 1ns/1ps

module spart_driver
	import spart_pkg::*, host_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	output spart_cmd_t cmd,
	inout  wire  [7:0] databus,
	input  logic       rda,
	input  logic       tbr,
	input  logic       clear_status_rd,
	input  logic       spart_data_wren,
	input  logic       spart_data_rden,
	input  word_t      data_tx,
	output word_t      data_rx,
	output status_t    status_register,
	output logic       data_rdy
);

	typedef enum logic [1:0] {S_IDLE, S_WRITE, S_READ} state_t;

	// Which bus cycle is out on cmd
	state_t      state;
	// Divisor writes done so far
	logic [1:0]  setup_cnt;
	logic        setup_done;
	// Next byte lane to send or fill
	logic [1:0]  wr_cnt;
	logic [1:0]  rd_cnt;
	// tbr seen low since the last byte
	logic        tbr_changed;
	// Receive side enabled by rden
	logic        rd_armed;
	logic        wr_busy;
	logic        wr_capture;
	logic        wr_start;
	logic        rd_start;
	logic        word_sent;
	logic        word_received;
	logic [7:0]  wr_byte;
	word_t       wr_word;
	// Lower three bytes of the incoming word
	logic [23:0] rd_buf;

	assign setup_done = (setup_cnt == 2'd2);
	assign wr_busy = ~status_register[STAT_WRITE_READY];
	assign wr_capture = spart_data_wren && !wr_busy;

	// Reads win over writes
	assign rd_start = setup_done && (state == S_IDLE) && rd_armed && rda;
	assign wr_start = setup_done && (state == S_IDLE) && !rd_start &&
		wr_busy && tbr && tbr_changed;

	// Lane counter has wrapped after the fourth byte
	assign word_sent = (state == S_WRITE) && (wr_cnt == 2'd0);
	assign word_received = (state == S_READ) && (rd_cnt == 2'd3);

	// Drive the bus only on write cycles
	assign databus = (cmd.cs && !cmd.rw) ? wr_byte : 8'hzz;

	//////////////////////////////////////////////////
	// Divisor setup and bus cycle FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
			setup_cnt <= 2'd0;
		else if (!setup_done)
			setup_cnt <= setup_cnt + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= S_IDLE;
			cmd <= '{cs: 1'b0, rw: 1'b1, addr: ADDR_DATA};
			wr_cnt <= 2'd0;
			tbr_changed <= 1'b1;
		end
		else
		begin
			if (!tbr)
				tbr_changed <= 1'b1;
			if (!setup_done)
			begin
				// Low divisor byte first, then high
				cmd <= '{cs: 1'b1, rw: 1'b0,
					addr: setup_cnt[0] ? ADDR_DIV_HI : ADDR_DIV_LO};
			end
			else if (rd_start)
			begin
				state <= S_READ;
				cmd <= '{cs: 1'b1, rw: 1'b1, addr: ADDR_DATA};
			end
			else if (wr_start)
			begin
				state <= S_WRITE;
				cmd <= '{cs: 1'b1, rw: 1'b0, addr: ADDR_DATA};
				wr_cnt <= wr_cnt + 1'b1;
				// Wait for the next tbr edge
				tbr_changed <= 1'b0;
			end
			else
			begin
				// One idle cycle after every access
				state <= S_IDLE;
				cmd <= '{cs: 1'b0, rw: 1'b1, addr: ADDR_DATA};
			end
		end
	end

	// Byte for the next write cycle
	always_ff @(posedge clk)
	begin
		if (!setup_done)
			wr_byte <= setup_cnt[0] ? DIV_HI : DIV_LO;
		else if (wr_start)
			wr_byte <= wr_word[{wr_cnt, 3'b000} +: 8];
	end

	//////////////////////////////////////////////////
	// Host words and status
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (wr_capture)
			wr_word <= data_tx;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rd_cnt <= 2'd0;
			rd_armed <= 1'b0;
			data_rx <= '0;
		end
		else
		begin
			// Stays armed for later words
			if (spart_data_rden)
				rd_armed <= 1'b1;
			if (state == S_READ)
				rd_cnt <= rd_cnt + 1'b1;
			// Held until the next word is complete
			if (word_received)
				data_rx <= {databus, rd_buf};
		end
	end

	// Byte lanes, low byte first
	always_ff @(posedge clk)
	begin
		if (state == S_READ && !word_received)
			rd_buf[{rd_cnt, 3'b000} +: 8] <= databus;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			status_register <= status_t'(1);
		else
		begin
			if (wr_capture)
				status_register[STAT_WRITE_READY] <= 1'b0;
			else if (word_sent)
				status_register[STAT_WRITE_READY] <= 1'b1;
			// New word beats a clear in the same cycle
			if (word_received)
				status_register[STAT_READ_DONE] <= 1'b1;
			else if (clear_status_rd)
				status_register[STAT_READ_DONE] <= 1'b0;
		end
	end

	// One cycle pulse per host request
	always_ff @(posedge clk)
	begin
		if (rst)
			data_rdy <= 1'b0;
		else
			data_rdy <= spart_data_wren | spart_data_rden;
	end

endmodule

//--- src/spart.sv
`timescale 1ns/1ps

module spart
	import spart_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  spart_cmd_t cmd,
	inout  wire  [7:0] databus,
	output logic       tbr,
	output logic       rda,
	output logic       txd,
	input  logic       rxd
);

	logic       bus_wr;
	logic       bus_rd;
	logic       div_wr_lo;
	logic       div_wr_hi;
	logic       tx_load;
	logic       rx_rd;
	logic       tick;
	logic       bus_drive;
	logic [7:0] rx_byte;
	logic [7:0] rd_byte;

	//////////////////////////////////////////////////
	// Register bus decode
	//////////////////////////////////////////////////

	assign bus_wr = cmd.cs & ~cmd.rw;
	assign bus_rd = cmd.cs & cmd.rw;

	assign div_wr_lo = bus_wr && (cmd.addr == ADDR_DIV_LO);
	assign div_wr_hi = bus_wr && (cmd.addr == ADDR_DIV_HI);
	assign tx_load = bus_wr && (cmd.addr == ADDR_DATA);
	// Clears rda one cycle after the read
	assign rx_rd = bus_rd && (cmd.addr == ADDR_DATA);

	// Read mux
	always_comb
	begin
		case (cmd.addr)
			ADDR_DATA:   rd_byte = rx_byte;
			ADDR_STATUS: rd_byte = {6'd0, rda, tbr};
			default:     rd_byte = 8'h00;
		endcase
	end

	// Divisor registers are write only
	assign bus_drive = bus_rd && (cmd.addr == ADDR_DATA || cmd.addr == ADDR_STATUS);
	assign databus = bus_drive ? rd_byte : 8'hzz;

	//////////////////////////////////////////////////
	// Baud, transmit and receive
	//////////////////////////////////////////////////

	spart_baud_gen spart_baud_gen_inst (
		.clk   (clk),
		.rst   (rst),
		.wr_lo (div_wr_lo),
		.wr_hi (div_wr_hi),
		.wdata (databus),
		.tick  (tick)
	);

	spart_tx spart_tx_inst (
		.clk   (clk),
		.rst   (rst),
		.tick  (tick),
		.load  (tx_load),
		.wdata (databus),
		.tbr   (tbr),
		.txd   (txd)
	);

	spart_rx spart_rx_inst (
		.clk   (clk),
		.rst   (rst),
		.tick  (tick),
		.rxd   (rxd),
		.rd    (rx_rd),
		.rdata (rx_byte),
		.rda   (rda)
	);

endmodule

//--- src/spart_rx.sv
`timescale 1ns/1ps

module spart_rx
	import spart_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       tick,
	input  logic       rxd,
	input  logic       rd,
	output logic [7:0] rdata,
	output logic       rda
);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

	rx_state_t  state;
	// Two flop synchroniser
	logic       rxd_meta;
	logic       rxd_sync;
	logic [3:0] tick_cnt;
	logic [2:0] bit_cnt;
	logic [7:0] shreg;
	// Mid point of a data or stop bit
	logic       sample;
	// Half bit into the start bit
	logic       mid_start;

	assign sample = tick && (tick_cnt == 4'(OVERSAMPLE - 1));
	assign mid_start = tick && (tick_cnt == 4'(OVERSAMPLE / 2 - 1));

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
		end
		else
		begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
		end
	end

	//////////////////////////////////////////////////
	// Frame FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= RX_IDLE;
			tick_cnt <= 4'd0;
			bit_cnt <= 3'd0;
			rda <= 1'b0;
		end
		else
		begin
			// Byte taken by a bus read
			if (rd)
				rda <= 1'b0;
			case (state)
				RX_IDLE:
				begin
					tick_cnt <= 4'd0;
					bit_cnt <= 3'd0;
					if (!rxd_sync)
						state <= RX_START;
				end
				RX_START:
				begin
					if (mid_start)
					begin
						tick_cnt <= 4'd0;
						// Line back high, only a glitch
						state <= rxd_sync ? RX_IDLE : RX_DATA;
					end
					else if (tick)
						tick_cnt <= tick_cnt + 1'b1;
				end
				RX_DATA:
				begin
					// Sample at tick 8 of each bit
					if (sample)
					begin
						tick_cnt <= 4'd0;
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= RX_STOP;
					end
					else if (tick)
						tick_cnt <= tick_cnt + 1'b1;
				end
				default:
				begin
					// Mid stop bit, framing error drops the byte
					if (sample)
					begin
						tick_cnt <= 4'd0;
						state <= RX_IDLE;
						if (rxd_sync)
							rda <= 1'b1;
					end
					else if (tick)
						tick_cnt <= tick_cnt + 1'b1;
				end
			endcase
		end
	end

	// Data bits arrive LSB first
	always_ff @(posedge clk)
	begin
		if (state == RX_DATA && sample)
			shreg <= {rxd_sync, shreg[7:1]};
	end

	always_ff @(posedge clk)
	begin
		if (state == RX_STOP && sample && rxd_sync)
			rdata <= shreg;
	end

endmodule

//--- src/spart_tx.sv
`timescale 1ns/1ps

module spart_tx
	import spart_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       tick,
	input  logic       load,
	input  logic [7:0] wdata,
	output logic       tbr,
	output logic       txd
);

	// Frame in progress
	logic       busy;
	// Ticks within current bit
	logic [3:0] tick_cnt;
	// Bit index, 0 start, 1..8 data, 9 stop
	logic [3:0] bit_cnt;
	// Stop, data and start bit, LSB goes out first
	logic [9:0] shreg;
	logic       bit_end;

	assign bit_end = tick && (tick_cnt == 4'(OVERSAMPLE - 1));

	//////////////////////////////////////////////////
	// Bit and tick counting
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			tick_cnt <= 4'd0;
			bit_cnt <= 4'd0;
		end
		else if (!busy)
		begin
			busy <= load;
			tick_cnt <= 4'd0;
			bit_cnt <= 4'd0;
		end
		else if (tick)
		begin
			if (bit_end)
			begin
				tick_cnt <= 4'd0;
				// Done at the end of the stop bit
				if (bit_cnt == 4'd9)
					busy <= 1'b0;
				else
					bit_cnt <= bit_cnt + 1'b1;
			end
			else
				tick_cnt <= tick_cnt + 1'b1;
		end
	end

	// Frame shift register
	always_ff @(posedge clk)
	begin
		if (!busy && load)
			shreg <= {1'b1, wdata, 1'b0};
		else if (busy && bit_end)
			shreg <= {1'b1, shreg[9:1]};
	end

	assign tbr = ~busy;
	// Line idles high
	assign txd = busy ? shreg[0] : 1'b1;

endmodule

//--- src/spart_baud_gen.sv
`timescale 1ns/1ps

module spart_baud_gen
(
	input  logic       clk,
	input  logic       rst,
	input  logic       wr_lo,
	input  logic       wr_hi,
	input  logic [7:0] wdata,
	output logic       tick
);

	// Divisor register pair
	logic [7:0]  div_lo;
	logic [7:0]  div_hi;
	// Cycles left until the next tick
	logic [15:0] cnt;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			div_lo <= 8'd0;
			div_hi <= 8'd0;
			cnt <= 16'd0;
		end
		else if (wr_lo)
		begin
			// Restart with the new low byte
			div_lo <= wdata;
			cnt <= {div_hi, wdata};
		end
		else if (wr_hi)
		begin
			div_hi <= wdata;
			cnt <= {wdata, div_lo};
		end
		else if (cnt == 16'd0)
			cnt <= {div_hi, div_lo};
		else
			cnt <= cnt - 1'b1;
	end

	// One pulse per divisor + 1 cycles
	assign tick = (cnt == 16'd0);

endmodule

//--- src/host_pkg.sv
package host_pkg;

	//////////////////////////////////////////////////
	// Host side word and status layout
	//////////////////////////////////////////////////

	// One host word, four serial bytes
	typedef logic [31:0] word_t;

	// Set while no word is being sent
	localparam int STAT_WRITE_READY = 0;
	// Set once a full word has arrived
	localparam int STAT_READ_DONE   = 1;

	// Upper bits read as zero
	typedef logic [31:0] status_t;

endpackage

//--- src/spart_pkg.sv
package spart_pkg;

	//////////////////////////////////////////////////
	// Register map of the byte bus
	//////////////////////////////////////////////////

	// Received or transmitted byte
	localparam logic [1:0] ADDR_DATA   = 2'b00;
	// Status byte, tbr in bit 0 and rda in bit 1
	localparam logic [1:0] ADDR_STATUS = 2'b01;
	// Baud divisor, low and high byte
	localparam logic [1:0] ADDR_DIV_LO = 2'b10;
	localparam logic [1:0] ADDR_DIV_HI = 2'b11;

	//////////////////////////////////////////////////
	// Baud setup
	//////////////////////////////////////////////////

	// Divisor programmed after reset
	localparam logic [7:0] DIV_LO = 8'hA3;
	localparam logic [7:0] DIV_HI = 8'h00;

	// Baud ticks per serial bit
	localparam int OVERSAMPLE = 16;

	// One bus cycle from the driver
	typedef struct packed {
		logic       cs;
		// High for a read
		logic       rw;
		logic [1:0] addr;
	} spart_cmd_t;

endpackage
